// File: filelist.f
+incdir+verification
rtl/mac_pkg.sv
rtl/rx_store_if.sv
rtl/crc32_engine.sv
rtl/tx_framer.sv
rtl/rx_parser.sv
rtl/rx_frame_buffer.sv
rtl/ethernet_mac.sv
verification/mac_tb.sv

// File: rtl/crc32_engine.sv
// ==========================================================================
// Byte-wide Ethernet CRC-32, reflected, LSB of each byte first
// The register is not inverted here, the FCS is ~crc
// ==========================================================================
module crc32_engine
    import mac_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        init,
    input  logic        en,
    input  logic [7:0]  data_byte,
    output logic [31:0] crc
);

    logic [31:0] crc_next;

    // Eight serial LFSR steps unrolled
    always_comb begin
        crc_next = crc;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_byte[i]) begin
                crc_next = (crc_next >> 1) ^ crc_poly_refl;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '1;
        end else if (init) begin
            crc <= '1;
        end else if (en) begin
            crc <= crc_next;
        end
    end

    a_init_en_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(init && en));

endmodule

// File: rtl/ethernet_mac.sv
// ==========================================================================
// Gigabit Ethernet MAC, GMII on the PHY side, 32-bit host words
// Both host ports use a four-phase req/ack handshake
// Fixed header, broadcast destination, EtherType 0x0800, payload 1..64
// ==========================================================================
module ethernet_mac
    import mac_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    // Host transmit
    input  logic [31:0]  tx_data,
    input  payload_len_t tx_len,
    input  logic         tx_req,
    output logic         tx_ack,
    // Host receive
    output logic [31:0]  rx_data,
    output payload_len_t rx_len,
    output logic         rx_last,
    output logic         rx_req,
    input  logic         rx_ack,
    // GMII
    output logic [7:0]   gmii_tx_d,
    output logic         gmii_tx_en,
    input  logic [7:0]   gmii_rx_d,
    input  logic         gmii_rx_dv,
    input  logic         gmii_rx_er,
    // Status
    output logic [31:0]  tx_frame_count,
    output logic [31:0]  rx_drop_count
);

    rx_store_if store_bus ();

    tx_framer u_tx_framer (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_data        (tx_data),
        .tx_len         (tx_len),
        .tx_req         (tx_req),
        .tx_ack         (tx_ack),
        .gmii_tx_d      (gmii_tx_d),
        .gmii_tx_en     (gmii_tx_en),
        .tx_frame_count (tx_frame_count)
    );

    rx_parser u_rx_parser (
        .clk           (clk),
        .rst_n         (rst_n),
        .gmii_rx_d     (gmii_rx_d),
        .gmii_rx_dv    (gmii_rx_dv),
        .gmii_rx_er    (gmii_rx_er),
        .store         (store_bus.parser),
        .rx_drop_count (rx_drop_count)
    );

    rx_frame_buffer u_rx_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .store   (store_bus.buffer),
        .rx_data (rx_data),
        .rx_len  (rx_len),
        .rx_last (rx_last),
        .rx_req  (rx_req),
        .rx_ack  (rx_ack)
    );

endmodule

// File: rtl/mac_pkg.sv
// ==========================================================================
// Frame constants and shared types of the GMII Ethernet MAC
// Payload is limited to 1..64 bytes and is never padded to 46
// Header bytes are indexed in wire order, byte 0 goes out first
// ==========================================================================
package mac_pkg;

    // ======================================================================
    // Frame format
    // ======================================================================
    localparam logic [47:0] local_mac     = 48'h02_00_00_00_00_01;
    localparam logic [47:0] broadcast_mac = 48'hFFFF_FFFF_FFFF;
    localparam logic [15:0] ether_type_ip = 16'h0800;
    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hD5;

    localparam int preamble_len = 7;
    localparam int header_len   = 14;
    localparam int fcs_len      = 4;
    localparam int gap_len      = 12;   // Idle cycles after the FCS
    localparam int max_payload  = 64;
    localparam int buf_words    = 16;

    // Reflected IEEE 802.3 CRC-32
    localparam logic [31:0] crc_poly_refl = 32'hEDB8_8320;
    localparam logic [31:0] crc_residue   = 32'hDEBB_20E3;

    // ======================================================================
    // FSM encodings
    // ======================================================================
    localparam logic [2:0] tx_st_collect  = 3'd0;
    localparam logic [2:0] tx_st_preamble = 3'd1;
    localparam logic [2:0] tx_st_sfd      = 3'd2;
    localparam logic [2:0] tx_st_header   = 3'd3;
    localparam logic [2:0] tx_st_payload  = 3'd4;
    localparam logic [2:0] tx_st_fcs      = 3'd5;
    localparam logic [2:0] tx_st_gap      = 3'd6;

    localparam logic [2:0] rx_st_idle     = 3'd0;
    localparam logic [2:0] rx_st_preamble = 3'd1;
    localparam logic [2:0] rx_st_header   = 3'd2;
    localparam logic [2:0] rx_st_body     = 3'd3;
    localparam logic [2:0] rx_st_skip     = 3'd4;   // Wait for end of carrier

    typedef logic [6:0] payload_len_t;  // Byte count 0..64

    typedef union packed {
        logic [0:header_len-1][7:0] bytes;
        struct packed {
            logic [47:0] dst;
            logic [47:0] src;
            logic [15:0] ether_type;
        } fields;
    } mac_header_u;

endpackage

// File: rtl/rx_frame_buffer.sv
// ==========================================================================
// Single-frame receive buffer, 16 words, bytes packed LSB first
// Words go out by four-phase rx_req/rx_ack, rx_last on the final one
// Bytes past rx_len in the final word read as zero
// ==========================================================================
module rx_frame_buffer
    import mac_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    rx_store_if.buffer   store,
    output logic [31:0]  rx_data,
    output payload_len_t rx_len,
    output logic         rx_last,
    output logic         rx_req,
    input  logic         rx_ack
);

    logic [3:0][7:0] mem [buf_words];
    logic [3:0]      rd_idx;
    logic            busy;
    payload_len_t    len_m1;
    logic [3:0][7:0] word;

    assign store.busy = busy;
    assign len_m1     = rx_len - 7'd1;
    assign rx_last    = rd_idx == len_m1[5:2];
    assign rx_data    = word;

    // Zero the tail of the final word
    always_comb begin
        word = mem[rd_idx];
        for (int b = 0; b < 4; b++) begin
            if ({1'b0, rd_idx, 2'(b)} >= rx_len) begin
                word[b] = 8'h00;
            end
        end
    end

    // FCS bytes land past the payload and are not stored
    always_ff @(posedge clk) begin
        if (store.wr_en && store.wr_index < 7'(max_payload)) begin
            mem[store.wr_index[5:2]][store.wr_index[1:0]] <= store.wr_byte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rx_req <= 1'b0;
            rd_idx <= '0;
            rx_len <= '0;
        end else if (store.commit) begin
            busy   <= 1'b1;
            rx_req <= 1'b1;
            rd_idx <= '0;
            rx_len <= store.commit_len;
        end else if (rx_req && rx_ack) begin
            rx_req <= 1'b0;
        end else if (busy && !rx_req && !rx_ack) begin
            if (rx_last) begin
                busy <= 1'b0;
            end else begin
                rd_idx <= rd_idx + 4'd1;
                rx_req <= 1'b1;
            end
        end
    end

    a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rx_req) |-> !rx_ack);

    // Parser must never finish a frame into an occupied buffer
    a_commit_free: assert property (@(posedge clk) disable iff (!rst_n)
        store.commit |-> !busy);

endmodule

// File: rtl/rx_parser.sv
// ==========================================================================
// GMII receive parser. Finds preamble and SFD, captures the header and
// streams every later byte, FCS included, to the frame buffer
// Frames are dropped on address, CRC, length, rx_er or a busy buffer
// ==========================================================================
module rx_parser
    import mac_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  gmii_rx_d,
    input  logic        gmii_rx_dv,
    input  logic        gmii_rx_er,
    rx_store_if.parser  store,
    output logic [31:0] rx_drop_count
);

    logic [2:0]  state;
    logic [7:0]  cnt;          // Saturates on oversized frames
    logic        accept;       // Buffer was free at the SFD
    logic        err_seen;
    mac_header_u hdr;
    logic [31:0] crc;
    logic        addr_ok;
    logic        len_ok;
    logic        frame_good;

    assign addr_ok    = hdr.fields.dst == local_mac || hdr.fields.dst == broadcast_mac;
    assign len_ok     = cnt >= 8'(fcs_len + 1) && cnt <= 8'(max_payload + fcs_len);
    assign frame_good = accept && !err_seen && addr_ok && len_ok && crc == crc_residue;

    assign store.wr_en    = state == rx_st_body && gmii_rx_dv && accept &&
                            cnt < 8'(max_payload + fcs_len);
    assign store.wr_index = cnt[6:0];
    assign store.wr_byte  = gmii_rx_d;

    // Runs over header, payload and FCS
    crc32_engine u_crc (
        .clk       (clk),
        .rst_n     (rst_n),
        .init      (state == rx_st_idle || state == rx_st_preamble),
        .en        (gmii_rx_dv && (state == rx_st_header || state == rx_st_body)),
        .data_byte (gmii_rx_d),
        .crc       (crc)
    );

    always_ff @(posedge clk) begin
        if (state == rx_st_header && gmii_rx_dv) begin
            hdr.bytes[cnt[3:0]] <= gmii_rx_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= rx_st_idle;
            cnt              <= '0;
            accept           <= 1'b0;
            err_seen         <= 1'b0;
            store.commit     <= 1'b0;
            store.commit_len <= '0;
            store.abort      <= 1'b0;
            rx_drop_count    <= '0;
        end else begin
            store.commit <= 1'b0;
            store.abort  <= 1'b0;
            if (store.abort) begin
                rx_drop_count <= rx_drop_count + 32'd1;
            end
            case (state)
                rx_st_idle: begin
                    if (gmii_rx_dv) begin
                        state <= (gmii_rx_d == preamble_byte) ? rx_st_preamble : rx_st_skip;
                    end
                end
                rx_st_preamble: begin
                    if (!gmii_rx_dv) begin
                        state <= rx_st_idle;
                    end else if (gmii_rx_d == sfd_byte) begin
                        state    <= rx_st_header;
                        cnt      <= '0;
                        accept   <= !store.busy;
                        err_seen <= gmii_rx_er;
                    end else if (gmii_rx_d != preamble_byte) begin
                        state <= rx_st_skip;
                    end
                end
                rx_st_header: begin
                    if (!gmii_rx_dv) begin
                        store.abort <= 1'b1;    // Runt, header incomplete
                        state       <= rx_st_idle;
                    end else begin
                        cnt      <= cnt + 8'd1;
                        err_seen <= err_seen | gmii_rx_er;
                        if (cnt == 8'(header_len - 1)) begin
                            cnt   <= '0;
                            state <= rx_st_body;
                        end
                    end
                end
                rx_st_body: begin
                    if (gmii_rx_dv) begin
                        if (cnt != 8'hFF) begin
                            cnt <= cnt + 8'd1;
                        end
                        err_seen <= err_seen | gmii_rx_er;
                    end else begin
                        // End of carrier, decide the frame
                        store.commit     <= frame_good;
                        store.commit_len <= payload_len_t'(cnt - 8'(fcs_len));
                        store.abort      <= !frame_good;
                        state            <= rx_st_idle;
                    end
                end
                default: begin
                    if (!gmii_rx_dv) begin
                        state <= rx_st_idle;
                    end
                end
            endcase
        end
    end

    // Committed length always fits the buffer
    a_commit_len: assert property (@(posedge clk) disable iff (!rst_n)
        store.commit |-> store.commit_len >= 7'd1 && store.commit_len <= 7'(max_payload));

endmodule

// File: rtl/rx_store_if.sv
// ==========================================================================
// Byte write path from the receive parser into the frame buffer
// wr_index counts from the first byte after the header and includes the FCS
// commit and abort are single-cycle pulses
// ==========================================================================
interface rx_store_if
    import mac_pkg::*;
();

    logic         wr_en;
    logic [6:0]   wr_index;
    logic [7:0]   wr_byte;
    logic         commit;
    payload_len_t commit_len;   // Payload bytes without the FCS
    logic         abort;
    logic         busy;         // High from commit until the last word is taken

    modport parser (
        output wr_en, wr_index, wr_byte, commit, commit_len, abort,
        input  busy
    );

    modport buffer (
        input  wr_en, wr_index, wr_byte, commit, commit_len, abort,
        output busy
    );

endinterface

// File: rtl/tx_framer.sv
// ==========================================================================
// Transmit framer. Collects ceil(tx_len/4) words, then sends one frame
// tx_len must stay in 1..64 and stable until the frame is collected
// gmii_tx_en rises 2 cycles after the last tx_req falls
// ==========================================================================
module tx_framer
    import mac_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  tx_data,
    input  payload_len_t tx_len,
    input  logic         tx_req,
    output logic         tx_ack,
    output logic [7:0]   gmii_tx_d,
    output logic         gmii_tx_en,
    output logic [31:0]  tx_frame_count
);

    logic [2:0]      state;
    logic [6:0]      cnt;           // Byte position inside the current field
    logic [3:0]      word_idx;
    payload_len_t    len_q;
    payload_len_t    len_m1;
    logic [3:0][7:0] payload_mem [buf_words];
    mac_header_u     hdr;
    logic [7:0]      next_byte;
    logic [31:0]     crc;
    logic [3:0][7:0] fcs;

    assign hdr.fields = '{dst: broadcast_mac, src: local_mac, ether_type: ether_type_ip};
    assign len_m1     = tx_len - 7'd1;
    assign fcs        = ~crc;   // Sent LSB byte first

    // Byte for the wire in the coming cycle
    always_comb begin
        case (state)
            tx_st_preamble: next_byte = preamble_byte;
            tx_st_sfd:      next_byte = sfd_byte;
            tx_st_header:   next_byte = hdr.bytes[cnt[3:0]];
            tx_st_payload:  next_byte = payload_mem[cnt[5:2]][cnt[1:0]];
            tx_st_fcs:      next_byte = fcs[cnt[1:0]];
            default:        next_byte = 8'h00;
        endcase
    end

    crc32_engine u_crc (
        .clk       (clk),
        .rst_n     (rst_n),
        .init      (state == tx_st_collect),
        .en        (state == tx_st_header || state == tx_st_payload),
        .data_byte (next_byte),
        .crc       (crc)
    );

    // Word store, written on the rising side of the handshake
    always_ff @(posedge clk) begin
        if (state == tx_st_collect && tx_req && !tx_ack) begin
            payload_mem[word_idx] <= tx_data;
        end
    end

    // ======================================================================
    // Framing FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= tx_st_collect;
            cnt            <= '0;
            word_idx       <= '0;
            len_q          <= '0;
            tx_ack         <= 1'b0;
            gmii_tx_d      <= '0;
            gmii_tx_en     <= 1'b0;
            tx_frame_count <= '0;
        end else begin
            gmii_tx_d  <= next_byte;
            gmii_tx_en <= state != tx_st_collect && state != tx_st_gap;
            cnt        <= cnt + 7'd1;
            case (state)
                tx_st_collect: begin
                    cnt <= '0;
                    if (tx_req && !tx_ack) begin
                        tx_ack <= 1'b1;
                    end else if (!tx_req && tx_ack) begin
                        tx_ack   <= 1'b0;
                        word_idx <= word_idx + 4'd1;
                        if (word_idx == len_m1[5:2]) begin    // Last word taken
                            word_idx <= '0;
                            len_q    <= tx_len;
                            state    <= tx_st_preamble;
                        end
                    end
                end
                tx_st_preamble: begin
                    if (cnt == 7'(preamble_len - 1)) begin
                        state <= tx_st_sfd;
                    end
                end
                tx_st_sfd: begin
                    cnt   <= '0;
                    state <= tx_st_header;
                end
                tx_st_header: begin
                    if (cnt == 7'(header_len - 1)) begin
                        cnt   <= '0;
                        state <= tx_st_payload;
                    end
                end
                tx_st_payload: begin
                    if (cnt == len_q - 7'd1) begin
                        cnt   <= '0;
                        state <= tx_st_fcs;
                    end
                end
                tx_st_fcs: begin
                    if (cnt == 7'(fcs_len - 1)) begin
                        cnt   <= '0;
                        state <= tx_st_gap;
                    end
                end
                default: begin  // Interframe gap
                    if (cnt == 7'd0) begin
                        tx_frame_count <= tx_frame_count + 32'd1;
                    end
                    if (cnt == 7'(gap_len - 1)) begin
                        state <= tx_st_collect;
                    end
                end
            endcase
        end
    end

    a_len_range: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req |-> (tx_len >= 7'd1 && tx_len <= 7'(max_payload)));

    // Line stays quiet for the whole gap after a frame
    a_gap_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii_tx_en) |-> !gmii_tx_en [*gap_len]);

endmodule

// File: verification/mac_tb_tasks.svh
// ==========================================================================
// Directed tests of the MAC, included inside mac_tb
// Each test ends with the DUT idle and no handshake pending
// ==========================================================================

    task automatic fill_payload();
        for (int i = 0; i < max_payload; i++) begin
            payload[i] = 8'($random(seed));
        end
    endtask

    // Whole frame as it appears on the wire
    task automatic build_frame(input logic [47:0] dst, input logic [47:0] src, input int len);
        logic [111:0] hdr;
        logic [31:0]  crc;
        logic [7:0]   b;
        hdr = {dst, src, ether_type_ip};
        crc = 32'hFFFF_FFFF;
        frame_q.delete();
        repeat (preamble_len) begin
            frame_q.push_back(preamble_byte);
        end
        frame_q.push_back(sfd_byte);
        for (int i = 0; i < header_len + len; i++) begin
            if (i < header_len) begin
                b = hdr[111 - 8 * i -: 8];
            end else begin
                b = payload[i - header_len];
            end
            crc = crc_step(crc, b);
            frame_q.push_back(b);
        end
        crc = ~crc;
        for (int j = 0; j < fcs_len; j++) begin
            frame_q.push_back(crc[8 * j +: 8]);     // LSB byte first
        end
    endtask

    task automatic transmit_and_check(input int len);
        logic [7:0]  got_q [$];
        logic [31:0] count_before;
        int          words;
        int          waited;
        count_before = tx_frame_count;
        words        = (len + 3) / 4;
        fill_payload();
        build_frame(broadcast_mac, local_mac, len);
        for (int w = 0; w < words; w++) begin
            @(posedge clk);
            tx_data <= {payload[4 * w + 3], payload[4 * w + 2], payload[4 * w + 1], payload[4 * w]};
            tx_len  <= payload_len_t'(len);
            tx_req  <= 1'b1;
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!tx_ack && waited < 20);
            assert (tx_ack) else begin
                other_errors++;
                $display("Transmit handshake stalled, tx_ack never rose for word %0d", w);
            end
            @(posedge clk);
            tx_req <= 1'b0;
            if (w < words - 1) begin
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (tx_ack && waited < 20);
            end
        end
        // Enable rises 2 cycles after the last tx_req falls
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end while (!gmii_tx_en && waited < 20);
        compare_value("gmii_tx_en rise delay", waited, 2);
        while (gmii_tx_en && got_q.size() < 200) begin
            got_q.push_back(gmii_tx_d);
            @(negedge clk);
        end
        compare_value("gmii_tx_en cycles", got_q.size(), frame_q.size());
        for (int i = 0; i < frame_q.size() && i < got_q.size(); i++) begin
            compare_value($sformatf("gmii_tx_d byte %0d", i), got_q[i], frame_q[i]);
        end
        for (int i = 0; i < gap_len; i++) begin
            compare_value("gmii_tx_en in gap", gmii_tx_en, 0);
            @(negedge clk);
        end
        compare_value("tx_frame_count", tx_frame_count, count_before + 1);
    endtask

    task automatic drive_rx_frame(input int er_at);
        foreach (frame_q[i]) begin
            @(posedge clk);
            gmii_rx_d  <= frame_q[i];
            gmii_rx_dv <= 1'b1;
            gmii_rx_er <= (i == er_at);
        end
        @(posedge clk);
        gmii_rx_d  <= 8'h00;
        gmii_rx_dv <= 1'b0;
        gmii_rx_er <= 1'b0;
    endtask

    // Takes every word of a held frame, expected bytes from payload[]
    task automatic read_rx_frame(input int len);
        logic [31:0] exp_word;
        int          words;
        int          waited;
        words = (len + 3) / 4;
        for (int w = 0; w < words; w++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!rx_req && waited < 20);
            assert (rx_req) else begin
                other_errors++;
                $display("Receive handshake stalled, rx_req never rose for word %0d", w);
            end
            for (int b = 0; b < 4; b++) begin
                exp_word[8 * b +: 8] = (4 * w + b < len) ? payload[4 * w + b] : 8'h00;
            end
            compare_value("rx_len", rx_len, len);
            compare_value($sformatf("rx_data word %0d", w), rx_data, exp_word);
            compare_value($sformatf("rx_last word %0d", w), rx_last, w == words - 1);
            @(posedge clk);
            rx_ack <= 1'b1;
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (rx_req && waited < 20);
            @(posedge clk);
            rx_ack <= 1'b0;
        end
        repeat (4) begin
            @(negedge clk);
            compare_value("rx_req after last word", rx_req, 0);
        end
    endtask

    task automatic receive_good(input logic [47:0] dst, input int len);
        logic [31:0] drops_before;
        drops_before = rx_drop_count;
        fill_payload();
        build_frame(dst, peer_mac, len);
        drive_rx_frame(-1);
        read_rx_frame(len);
        compare_value("rx_drop_count", rx_drop_count, drops_before);
    endtask

    task automatic expect_drop(input int er_at);
        logic [31:0] drops_before;
        drops_before = rx_drop_count;
        drive_rx_frame(er_at);
        repeat (gap_len) begin
            @(negedge clk);
            compare_value("rx_req on dropped frame", rx_req, 0);
        end
        compare_value("rx_drop_count", rx_drop_count, drops_before + 1);
    endtask

    task automatic rx_drop_cases();
        logic [31:0] drops_start;
        drops_start = rx_drop_count;
        fill_payload();
        build_frame(local_mac, peer_mac, 16);
        frame_q[frame_q.size() - 1] ^= 8'h01;       // Bad FCS
        expect_drop(-1);
        build_frame(48'h02_00_00_00_00_02, peer_mac, 16);
        expect_drop(-1);
        build_frame(local_mac, peer_mac, 16);
        expect_drop(preamble_len + 1 + header_len + 3);
        compare_value("rx_drop_count after three drops", rx_drop_count, drops_start + 3);
    endtask

    // Second frame arrives while the first is still held
    task automatic rx_busy_buffer();
        logic [31:0] drops_before;
        drops_before = rx_drop_count;
        fill_payload();
        build_frame(local_mac, peer_mac, 12);
        drive_rx_frame(-1);
        held = payload;
        fill_payload();
        build_frame(local_mac, peer_mac, 20);
        drive_rx_frame(-1);
        repeat (gap_len) @(negedge clk);
        compare_value("rx_drop_count with busy buffer", rx_drop_count, drops_before + 1);
        compare_value("rx_req for held frame", rx_req, 1);
        payload = held;
        read_rx_frame(12);
    endtask

// File: verification/mac_tb.sv
// ==========================================================================
// Directed testbench for the GMII Ethernet MAC
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Payload bytes come from $random with a fixed seed
// ==========================================================================
module mac_tb
    import mac_pkg::*;
();

    logic         clk = 1'b0;
    logic         rst_n;
    logic [31:0]  tx_data;
    payload_len_t tx_len;
    logic         tx_req;
    logic         tx_ack;
    logic [31:0]  rx_data;
    payload_len_t rx_len;
    logic         rx_last;
    logic         rx_req;
    logic         rx_ack;
    logic [7:0]   gmii_tx_d;
    logic         gmii_tx_en;
    logic [7:0]   gmii_rx_d;
    logic         gmii_rx_dv;
    logic         gmii_rx_er;
    logic [31:0]  tx_frame_count;
    logic [31:0]  rx_drop_count;

    integer      seed;
    int          value_errors = 0;
    int          other_errors = 0;
    logic [47:0] peer_mac = 48'h02_00_00_00_00_42;   // Source of received frames
    logic [7:0]  payload [max_payload];
    logic [7:0]  held    [max_payload];
    logic [7:0]  frame_q [$];                        // Wire bytes, preamble to FCS

    always #4 clk = ~clk;

    ethernet_mac dut (.*);

    // ======================================================================
    // Reference CRC-32, reflected 0x04C11DB7, one byte per call
    // ======================================================================
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic compare_value(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp, got);
        end
    endtask

    `include "mac_tb_tasks.svh"

    // Six tests of at most 400 cycles each
    initial begin
        #(6 * 400 * 8);
        $display("Timeout, the tests did not finish within %0d time units", 6 * 400 * 8);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed       = 32'he955;
        rst_n      <= 1'b0;
        tx_data    <= '0;
        tx_len     <= '0;
        tx_req     <= 1'b0;
        rx_ack     <= 1'b0;
        gmii_rx_d  <= '0;
        gmii_rx_dv <= 1'b0;
        gmii_rx_er <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_value("gmii_tx_en after reset", gmii_tx_en, 0);
        compare_value("tx_ack after reset", tx_ack, 0);
        compare_value("rx_req after reset", rx_req, 0);
        compare_value("tx_frame_count after reset", tx_frame_count, 0);
        compare_value("rx_drop_count after reset", rx_drop_count, 0);

        transmit_and_check(8);              // Two full words
        transmit_and_check(5);              // Only the low byte of word 2
        receive_good(local_mac, 10);        // Unicast, three words
        receive_good(broadcast_mac, 7);
        rx_drop_cases();
        rx_busy_buffer();

        $display("Errors: %0d wrong values, %0d handshake or timing failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
